// ==== verification/wb_stage_testdata.txt ====
# test pc rd result reg_write csr_addr csr_write branch_target is_branch ecall mret
# gpr_rb csr_rb exp_next_pc exp_gpr exp_csr  (test in decimal, the rest in hex)
1 80000000 01 11111111 1 000 0 00000000 0 0 0 01 305 80000004 11111111 80000000
2 80000004 02 22222222 0 000 0 00000000 0 0 0 02 342 80000008 00000000 00000000
3 80000008 00 deadbeef 1 000 0 00000000 0 0 0 00 341 8000000c 00000000 80000000
4 8000000c 03 80000100 0 305 1 00000000 0 0 0 01 305 80000010 11111111 80000100
5 80000010 04 12345678 1 300 1 00000000 0 0 0 04 300 80000014 12345678 00000000
6 80000014 05 00000555 1 000 0 80000040 1 0 0 05 305 80000040 00000555 80000100
7 80000040 00 00000000 0 000 0 00000000 0 1 0 01 342 80000100 11111111 0000000b
8 80000100 06 80000044 1 341 1 00000000 0 0 0 06 341 80000104 80000044 80000044
9 80000104 00 00000000 0 000 0 00000000 0 0 1 00 341 80000044 00000000 80000044
10 80000044 01 aaaaaaaa 1 000 0 00000000 0 0 0 01 342 80000048 aaaaaaaa 0000000b
11 80000048 01 bbbbbbbb 1 000 0 00000000 0 0 0 01 305 8000004c bbbbbbbb 80000100
12 8000004c 00 0000dead 0 341 1 00000000 0 1 0 05 341 80000100 00000555 8000004c
13 80000100 00 00000000 0 000 0 00000000 0 0 1 02 342 8000004c 00000000 0000000b
14 8000004c 1f ffffffff 1 000 0 80000000 1 0 0 1f 342 80000000 ffffffff 0000000b
15 80000000 1f 00000000 0 342 1 00000000 0 0 0 1f 342 80000004 ffffffff 00000000
16 fffffffc 07 00000007 1 300 0 00000000 0 0 0 07 300 00000000 00000007 00000000

// ==== wb_stage.f ====
hw/rv_isa_pkg.sv
hw/wb_ctrl_pkg.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/wb_control.sv
hw/wb_stage.sv
verification/wb_stage_properties.sv
verification/wb_stage_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module wb_stage_tb -Mdir obj_dir -f wb_stage.f

run: compile
	./obj_dir/Vwb_stage_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "no verdict in sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== verification/wb_stage_tb.sv ====
`timescale 1ns/1ps

module wb_stage_tb;

	localparam int    clk_period   = 40;
	localparam int    reset_cycles = 4;
	localparam int    max_lines    = 64;
	localparam string data_file    = "verification/wb_stage_testdata.txt";

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  lsu_valid;
	logic                  lsu_ready;
	rv_isa_pkg::word_t     pc;
	rv_isa_pkg::reg_addr_t rd;
	rv_isa_pkg::word_t     result;
	logic                  reg_write;
	rv_isa_pkg::csr_addr_t csr_addr;
	logic                  csr_write;
	rv_isa_pkg::word_t     branch_target;
	logic                  is_branch;
	logic                  ecall;
	logic                  mret;
	logic                  ifu_valid;
	logic                  ifu_ready;
	rv_isa_pkg::word_t     next_pc;
	rv_isa_pkg::reg_addr_t rs_addr;
	rv_isa_pkg::word_t     rs_data;
	rv_isa_pkg::csr_addr_t csr_raddr;
	rv_isa_pkg::word_t     csr_rdata;

	logic [31:0] tv [0:max_lines-1][0:15]; // one row per data line
	int          num_lines;
	int          cur_test;
	int          checks;
	int          errors;
	integer      seed;

	always #(clk_period / 2) clk = ~clk;

	wb_stage u_wb_stage (
		.clk (clk), .rst (rst),
		.lsu_valid (lsu_valid), .lsu_ready (lsu_ready),
		.pc (pc), .rd (rd), .result (result), .reg_write (reg_write),
		.csr_addr (csr_addr), .csr_write (csr_write),
		.branch_target (branch_target), .is_branch (is_branch),
		.ecall (ecall), .mret (mret),
		.ifu_valid (ifu_valid), .ifu_ready (ifu_ready), .next_pc (next_pc),
		.rs_addr (rs_addr), .rs_data (rs_data),
		.csr_raddr (csr_raddr), .csr_rdata (csr_rdata)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("** Error: test %0d, %s = %h, expected %h", cur_test, name, actual, expected);
			errors++;
		end
	endtask

	// put data line i on the memory stage ports
	task automatic present(input int i);
		lsu_valid     <= 1'b1;
		pc            <= tv[i][1];
		rd            <= 5'(tv[i][2]);
		result        <= tv[i][3];
		reg_write     <= tv[i][4][0];
		csr_addr      <= 12'(tv[i][5]);
		csr_write     <= tv[i][6][0];
		branch_target <= tv[i][7];
		is_branch     <= tv[i][8][0];
		ecall         <= tv[i][9][0];
		mret          <= tv[i][10][0];
	endtask

	task automatic check_reset_state;
		rv_isa_pkg::csr_addr_t csr_list [4];
		logic [31:0]           csr_exp [4];
		csr_list = '{rv_isa_pkg::csr_mtvec, rv_isa_pkg::csr_mepc,
			rv_isa_pkg::csr_mcause, 12'h300};
		csr_exp  = '{rv_isa_pkg::reset_pc, rv_isa_pkg::reset_pc, 32'd0, 32'd0};
		cur_test = 0;
		@(negedge clk);
		check_value("lsu_ready", 32'(lsu_ready), 32'd1);
		check_value("ifu_valid", 32'(ifu_valid), 32'd0);
		for (int r = 0; r < 32; r++) begin
			@(posedge clk);
			rs_addr   <= 5'(r);
			csr_raddr <= csr_list[r % 4];
			@(negedge clk);
			check_value("rs_data", rs_data, 32'd0);
			check_value("csr_rdata", csr_rdata, csr_exp[r % 4]);
		end
		$display("test 0: reset state %s", (errors == 0) ? "ok" : "mismatch");
	endtask

	// starts and ends on a falling edge
	task automatic run_line(input int i);
		int stalls;
		int err_before;
		cur_test   = int'(tv[i][0]);
		err_before = errors;
		stalls     = {$random(seed)} % 4;
		while (!lsu_ready) @(negedge clk);
		@(posedge clk); // accepting edge
		if (i + 1 < num_lines) begin
			present(i + 1); // offered during back-pressure
		end else begin
			lsu_valid <= 1'b0;
		end
		rs_addr   <= 5'(tv[i][11]);
		csr_raddr <= 12'(tv[i][12]);
		ifu_ready <= (stalls == 0); // no stall, fetch takes it at once
		@(negedge clk);
		check_value("ifu_valid", 32'(ifu_valid), 32'd1);
		while (!ifu_valid) @(negedge clk);
		check_value("lsu_ready", 32'(lsu_ready), 32'd0);
		check_value("next_pc", next_pc, tv[i][13]);
		for (int s = 0; s < stalls; s++) begin
			@(posedge clk); // fetch stalls on this edge
			if (s == stalls - 1) begin
				ifu_ready <= 1'b1;
			end
			@(negedge clk);
			check_value("ifu_valid", 32'(ifu_valid), 32'd1);
			check_value("lsu_ready", 32'(lsu_ready), 32'd0);
			check_value("next_pc", next_pc, tv[i][13]);
		end
		@(posedge clk); // hand-over edge
		ifu_ready <= 1'b0;
		@(negedge clk);
		check_value("ifu_valid", 32'(ifu_valid), 32'd0);
		check_value("lsu_ready", 32'(lsu_ready), 32'd1);
		check_value("rs_data", rs_data, tv[i][14]);
		check_value("csr_rdata", csr_rdata, tv[i][15]);
		$display("test %0d: %0d stall cycles, %s", cur_test, stalls,
			(errors == err_before) ? "ok" : "mismatch");
	endtask

	initial begin
		int    fd;
		int    n;
		string line;
		rst           = 1'b1;
		lsu_valid     = 1'b0;
		pc            = '0;
		rd            = '0;
		result        = '0;
		reg_write     = 1'b0;
		csr_addr      = '0;
		csr_write     = 1'b0;
		branch_target = '0;
		is_branch     = 1'b0;
		ecall         = 1'b0;
		mret          = 1'b0;
		ifu_ready     = 1'b0;
		rs_addr       = '0;
		csr_raddr     = '0;
		seed          = 97;
		checks        = 0;
		errors        = 0;
		num_lines     = 0;
		fd = $fopen(data_file, "r");
		if (fd == 0) begin
			$display("could not open the test data file %s", data_file);
			$display("TESTS FAILED");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() == 0 || line.substr(0, 0) == "#") continue; // column notes
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					tv[num_lines][0], tv[num_lines][1], tv[num_lines][2], tv[num_lines][3],
					tv[num_lines][4], tv[num_lines][5], tv[num_lines][6], tv[num_lines][7],
					tv[num_lines][8], tv[num_lines][9], tv[num_lines][10], tv[num_lines][11],
					tv[num_lines][12], tv[num_lines][13], tv[num_lines][14], tv[num_lines][15]);
				if (n == 16 && num_lines < max_lines - 1) num_lines++;
			end
			$fclose(fd);
			fork
				begin
					#((num_lines * 10 + 20) * clk_period);
					$display("timeout: run did not finish in %0d clock periods",
						num_lines * 10 + 20);
					$display("TESTS FAILED");
					$finish;
				end
			join_none
			repeat (reset_cycles) @(posedge clk);
			rst <= 1'b0;
			check_reset_state();
			if (num_lines == 0) begin
				$display("no test lines found in %s", data_file);
				errors++;
			end else begin
				@(posedge clk);
				present(0);
				@(negedge clk);
				for (int i = 0; i < num_lines; i++) begin
					run_line(i);
				end
			end
			errors += u_wb_stage.u_ctrl.u_props.fail_count; // assertion failures
			$display("%0d tests, %0d checks, %0d errors", num_lines + 1, checks, errors);
			if (errors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
		end
		$finish;
	end

endmodule

// ==== verification/wb_stage_properties.sv ====
`timescale 1ns/1ps

module wb_stage_properties (
	input logic              clk,
	input logic              rst,
	input logic              lsu_valid,
	input logic              lsu_ready,
	input logic              gpr_we,
	input logic              ifu_valid,
	input logic              ifu_ready,
	input rv_isa_pkg::word_t next_pc
);

	int unsigned fail_count = 0;

	// once accepted, only the fetch side is open
	a_accept_handover: assert property (@(posedge clk) disable iff (rst)
		(lsu_valid && lsu_ready) |=> (ifu_valid && !lsu_ready))
		else begin
			$error("accepted instruction not followed by the hand-over state");
			fail_count++;
		end

	// commit happens in idle and is followed by the offer to fetch
	a_gpr_we_on_accept: assert property (@(posedge clk) disable iff (rst)
		gpr_we |-> (!ifu_valid ##1 ifu_valid))
		else begin
			$error("gpr_we high without an accepting edge");
			fail_count++;
		end

	// fetch stalled, offer must not move
	a_next_pc_hold: assert property (@(posedge clk) disable iff (rst)
		(ifu_valid && !ifu_ready) |=> (ifu_valid && $stable(next_pc)))
		else begin
			$error("next_pc or ifu_valid changed under back-pressure");
			fail_count++;
		end

endmodule

bind wb_control wb_stage_properties u_props (.*);

// ==== hw/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
	input  logic                  clk,
	input  logic                  rst,

	// memory stage side
	input  logic                  lsu_valid,
	output logic                  lsu_ready,
	input  rv_isa_pkg::word_t     pc,
	input  rv_isa_pkg::reg_addr_t rd,
	input  rv_isa_pkg::word_t     result,
	input  logic                  reg_write,
	input  rv_isa_pkg::csr_addr_t csr_addr,
	input  logic                  csr_write,
	input  rv_isa_pkg::word_t     branch_target,
	input  logic                  is_branch,
	input  logic                  ecall,
	input  logic                  mret,

	// fetch stage side
	output logic                  ifu_valid,
	input  logic                  ifu_ready,
	output rv_isa_pkg::word_t     next_pc,

	// execute stage read ports
	input  rv_isa_pkg::reg_addr_t rs_addr,
	output rv_isa_pkg::word_t     rs_data,
	input  rv_isa_pkg::csr_addr_t csr_raddr,
	output rv_isa_pkg::word_t     csr_rdata
);

	logic                  gpr_we;
	rv_isa_pkg::reg_addr_t gpr_waddr;
	rv_isa_pkg::word_t     gpr_wdata;
	logic                  csr_we;
	rv_isa_pkg::csr_addr_t csr_waddr;
	rv_isa_pkg::word_t     csr_wdata;
	logic                  trap_ecall;
	rv_isa_pkg::word_t     mtvec;
	rv_isa_pkg::word_t     mepc;

	gpr_file u_gpr (
		.clk   (clk),
		.rst   (rst),
		.we    (gpr_we),
		.waddr (gpr_waddr),
		.wdata (gpr_wdata),
		.raddr (rs_addr),
		.rdata (rs_data)
	);

	csr_file u_csr (
		.clk        (clk),
		.rst        (rst),
		.we         (csr_we),
		.waddr      (csr_waddr),
		.wdata      (csr_wdata),
		.trap_ecall (trap_ecall),
		.trap_pc    (pc),        // pc of the ecall itself
		.raddr      (csr_raddr),
		.rdata      (csr_rdata),
		.mtvec      (mtvec),
		.mepc       (mepc)
	);

	wb_control u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.lsu_valid     (lsu_valid),
		.lsu_ready     (lsu_ready),
		.pc            (pc),
		.rd            (rd),
		.result        (result),
		.reg_write     (reg_write),
		.csr_addr      (csr_addr),
		.csr_write     (csr_write),
		.branch_target (branch_target),
		.is_branch     (is_branch),
		.ecall         (ecall),
		.mret          (mret),
		.mtvec         (mtvec),
		.mepc          (mepc),
		.gpr_we        (gpr_we),
		.gpr_waddr     (gpr_waddr),
		.gpr_wdata     (gpr_wdata),
		.csr_we        (csr_we),
		.csr_waddr     (csr_waddr),
		.csr_wdata     (csr_wdata),
		.trap_ecall    (trap_ecall),
		.ifu_valid     (ifu_valid),
		.ifu_ready     (ifu_ready),
		.next_pc       (next_pc)
	);

endmodule

// ==== hw/wb_control.sv ====
`timescale 1ns/1ps

module wb_control (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  lsu_valid,
	output logic                  lsu_ready,

	input  rv_isa_pkg::word_t     pc,
	input  rv_isa_pkg::reg_addr_t rd,
	input  rv_isa_pkg::word_t     result,
	input  logic                  reg_write,
	input  rv_isa_pkg::csr_addr_t csr_addr,
	input  logic                  csr_write,
	input  rv_isa_pkg::word_t     branch_target,
	input  logic                  is_branch,
	input  logic                  ecall,
	input  logic                  mret,

	input  rv_isa_pkg::word_t     mtvec,
	input  rv_isa_pkg::word_t     mepc,

	output logic                  gpr_we,
	output rv_isa_pkg::reg_addr_t gpr_waddr,
	output rv_isa_pkg::word_t     gpr_wdata,

	output logic                  csr_we,
	output rv_isa_pkg::csr_addr_t csr_waddr,
	output rv_isa_pkg::word_t     csr_wdata,
	output logic                  trap_ecall,

	output logic                  ifu_valid,
	input  logic                  ifu_ready,
	output rv_isa_pkg::word_t     next_pc
);

	wb_ctrl_pkg::wb_state_t state;
	wb_ctrl_pkg::wb_state_t state_next;
	logic                   accept;
	rv_isa_pkg::word_t      pc_sel;

	assign lsu_ready = (state == wb_ctrl_pkg::wb_idle);
	assign ifu_valid = (state == wb_ctrl_pkg::wb_handover);
	assign accept    = lsu_valid && lsu_ready; // one retiring instruction

	always_comb begin
		case (state)
			wb_ctrl_pkg::wb_idle:
				state_next = accept ? wb_ctrl_pkg::wb_handover : wb_ctrl_pkg::wb_idle;
			wb_ctrl_pkg::wb_handover:
				state_next = ifu_ready ? wb_ctrl_pkg::wb_idle : wb_ctrl_pkg::wb_handover;
			default:
				state_next = wb_ctrl_pkg::wb_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wb_ctrl_pkg::wb_idle;
		end else begin
			state <= state_next;
		end
	end

	// writes only on the accepting edge
	assign gpr_we     = accept && reg_write;
	assign gpr_waddr  = rd;
	assign gpr_wdata  = result;
	assign csr_we     = accept && csr_write;
	assign csr_waddr  = csr_addr;
	assign csr_wdata  = result;
	assign trap_ecall = accept && ecall; // mepc gets pc in csr_file

	// ecall beats mret beats branch
	always_comb begin
		if (ecall) begin
			pc_sel = mtvec;
		end else if (mret) begin
			pc_sel = mepc;
		end else if (is_branch) begin
			pc_sel = branch_target;
		end else begin
			pc_sel = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			next_pc <= rv_isa_pkg::reset_pc;
		end else if (accept) begin
			next_pc <= pc_sel; // held through back-pressure
		end
	end

endmodule

// ==== hw/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  rv_isa_pkg::csr_addr_t waddr,
	input  rv_isa_pkg::word_t     wdata,
	input  logic                  trap_ecall,
	input  rv_isa_pkg::word_t     trap_pc,
	input  rv_isa_pkg::csr_addr_t raddr,
	output rv_isa_pkg::word_t     rdata,
	output rv_isa_pkg::word_t     mtvec,
	output rv_isa_pkg::word_t     mepc
);

	rv_isa_pkg::word_t mtvec_q;
	rv_isa_pkg::word_t mepc_q;
	rv_isa_pkg::word_t mcause_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			mtvec_q  <= rv_isa_pkg::reset_pc;
			mepc_q   <= rv_isa_pkg::reset_pc;
			mcause_q <= '0;
		end else if (trap_ecall) begin // trap wins over a plain write
			mepc_q   <= trap_pc;
			mcause_q <= rv_isa_pkg::cause_ecall_m;
		end else if (we) begin
			case (waddr)
				rv_isa_pkg::csr_mtvec:  mtvec_q  <= wdata;
				rv_isa_pkg::csr_mepc:   mepc_q   <= wdata;
				rv_isa_pkg::csr_mcause: mcause_q <= wdata;
				default: ; // unknown csr, write dropped
			endcase
		end
	end

	// read port for the execute stage
	always_comb begin
		case (raddr)
			rv_isa_pkg::csr_mtvec:  rdata = mtvec_q;
			rv_isa_pkg::csr_mepc:   rdata = mepc_q;
			rv_isa_pkg::csr_mcause: rdata = mcause_q;
			default:                rdata = '0;
		endcase
	end

	assign mtvec = mtvec_q; // trap target
	assign mepc  = mepc_q;  // mret target

endmodule

// ==== hw/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  rv_isa_pkg::reg_addr_t waddr,
	input  rv_isa_pkg::word_t     wdata,
	input  rv_isa_pkg::reg_addr_t raddr,
	output rv_isa_pkg::word_t     rdata
);

	rv_isa_pkg::word_t regs [31:1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 5'd0)) begin // x0 writes dropped
			regs[waddr] <= wdata;
		end
	end

	// asynchronous read, x0 hardwired
	always_comb begin
		if (raddr == 5'd0) begin
			rdata = '0;
		end else begin
			rdata = regs[raddr];
		end
	end

endmodule

// ==== hw/wb_ctrl_pkg.sv ====
package wb_ctrl_pkg;

	// write-back handshake states
	typedef enum logic {
		wb_idle,     // waiting on the memory stage
		wb_handover  // next pc offered to fetch
	} wb_state_t;

endpackage

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// data and address width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;     // one data or address word
	typedef logic [4:0]      reg_addr_t; // gpr number
	typedef logic [11:0]     csr_addr_t; // csr number

	// machine-mode csr numbers
	localparam csr_addr_t csr_mtvec  = 12'h305;
	localparam csr_addr_t csr_mepc   = 12'h341;
	localparam csr_addr_t csr_mcause = 12'h342;

	// environment call from m-mode
	localparam word_t cause_ecall_m = 32'd11;

	// boot address, also the trap vector until software sets one
	localparam word_t reset_pc = 32'h8000_0000;

endpackage
